// File: logic/config_regs.sv
`timescale 1ns/1ps

module config_regs (
    input  logic                    m00_axis_aclk,
    input  logic                    m00_axis_aresetn,
    input  logic                    cfg_req,
    input  udp_gen_pkg::cfg_req_t   cfg_cmd,
    output logic                    cfg_ack,
    output logic [31:0]             cfg_rdata,
    input  logic                    frame_done,
    output udp_gen_pkg::frame_cfg_t cfg_live,
    output logic [31:0]             delay
);

    logic [31:0] sent_count;
    logic        access;

    // New request seen while the previous handshake is closed
    assign access = cfg_req && !cfg_ack;

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            cfg_ack          <= 1'b0;
            delay            <= udp_gen_pkg::default_delay;
            cfg_live.dst_mac <= udp_gen_pkg::default_dst_mac;
            cfg_live.dst_ip  <= udp_gen_pkg::default_dst_ip;
            sent_count       <= '0;
        end else begin
            if (access) begin
                cfg_ack <= 1'b1;
            end else if (!cfg_req) begin
                cfg_ack <= 1'b0;   // Host dropped req, close the handshake
            end

            if (access && cfg_cmd.we) begin
                case (cfg_cmd.addr)
                    udp_gen_pkg::reg_delay:  delay <= cfg_cmd.wdata;
                    udp_gen_pkg::reg_mac_hi: cfg_live.dst_mac[47:16] <= cfg_cmd.wdata;
                    udp_gen_pkg::reg_mac_lo: cfg_live.dst_mac[15:0] <= cfg_cmd.wdata[15:0];
                    udp_gen_pkg::reg_dst_ip: cfg_live.dst_ip <= cfg_cmd.wdata;
                    default: ;   // Sent count is not writable
                endcase
            end

            if (frame_done) begin
                sent_count <= sent_count + 32'd1;
            end
        end
    end

    // Read data is captured with the access and held through the ack phase
    always_ff @(posedge m00_axis_aclk) begin
        if (access) begin
            case (cfg_cmd.addr)
                udp_gen_pkg::reg_sent_count: cfg_rdata <= sent_count;
                udp_gen_pkg::reg_delay:      cfg_rdata <= delay;
                udp_gen_pkg::reg_mac_hi:     cfg_rdata <= cfg_live.dst_mac[47:16];
                udp_gen_pkg::reg_mac_lo:     cfg_rdata <= {16'h0000, cfg_live.dst_mac[15:0]};
                udp_gen_pkg::reg_dst_ip:     cfg_rdata <= cfg_live.dst_ip;
                default:                     cfg_rdata <= '0;
            endcase
        end
    end

endmodule

// File: logic/frame_word_mux.sv
`timescale 1ns/1ps

module frame_word_mux (
    input  logic [4:0]              beat_idx,
    input  udp_gen_pkg::frame_cfg_t cfg_snap,
    input  logic [15:0]             ip_csum,
    output udp_gen_pkg::beat_t      beat
);

    localparam int hdr_w = udp_gen_pkg::hdr_bytes * 8;

    logic [hdr_w-1:0] hdr_vec;   // Byte 0 of the frame in the top bits

    assign hdr_vec = {
        cfg_snap.dst_mac,
        udp_gen_pkg::src_mac,
        udp_gen_pkg::ether_type,
        udp_gen_pkg::ip_ver_ihl,
        8'h00,                        // TOS
        udp_gen_pkg::ip_total_len,
        udp_gen_pkg::ip_id,
        udp_gen_pkg::ip_flags,
        udp_gen_pkg::ip_ttl,
        udp_gen_pkg::ip_proto_udp,
        ip_csum,
        udp_gen_pkg::src_ip,
        cfg_snap.dst_ip,
        udp_gen_pkg::udp_port,        // Source port
        udp_gen_pkg::udp_port,        // Dest port
        udp_gen_pkg::udp_len,
        16'h0000                      // UDP checksum unused
    };

    // Keep per beat, zero past the end of the frame
    always_comb begin
        if (beat_idx < 5'(udp_gen_pkg::beats_per_frame - 1)) begin
            beat.keep = '1;
        end else if (beat_idx == 5'(udp_gen_pkg::beats_per_frame - 1)) begin
            beat.keep = udp_gen_pkg::last_keep;
        end else begin
            beat.keep = '0;
        end
    end

    always_comb begin : place_bytes
        int          n;
        int          p;
        int          w;
        logic [15:0] val;
        logic [7:0]  byte_val;

        for (int lane = 0; lane < udp_gen_pkg::keep_w; lane++) begin
            n        = int'(beat_idx) * 8 + lane;
            p        = n - udp_gen_pkg::hdr_bytes;
            w        = p / 2;
            val      = '0;
            byte_val = '0;
            if (n < udp_gen_pkg::hdr_bytes) begin
                byte_val = hdr_vec[(udp_gen_pkg::hdr_bytes - 1 - n) * 8 +: 8];
            end else if (w < udp_gen_pkg::payload_words) begin
                // Even words count up, odd words count down from 255
                if (w % 2 == 0) begin
                    val = 16'(w / 2);
                end else begin
                    val = 16'(255 - w / 2);
                end
                byte_val = (p % 2 == 0) ? val[7:0] : val[15:8];   // Low byte first
            end
            beat.data[lane*8 +: 8] = byte_val;   // Zero past the end of the payload
        end
    end

endmodule

// File: logic/ip_checksum.sv
`timescale 1ns/1ps

module ip_checksum (
    input  logic                    m00_axis_aclk,
    input  logic                    m00_axis_aresetn,
    input  udp_gen_pkg::frame_cfg_t cfg_snap,
    output logic [15:0]             ip_csum
);

    logic [15:0] hdr_words [10];
    logic [19:0] sum;      // Ten 16-bit words fit in 20 bits
    logic [16:0] fold1;
    logic [15:0] fold2;

    // IPv4 header as 16-bit words, checksum field taken as zero
    always_comb begin
        hdr_words[0] = {udp_gen_pkg::ip_ver_ihl, 8'h00};
        hdr_words[1] = udp_gen_pkg::ip_total_len;
        hdr_words[2] = udp_gen_pkg::ip_id;
        hdr_words[3] = udp_gen_pkg::ip_flags;
        hdr_words[4] = {udp_gen_pkg::ip_ttl, udp_gen_pkg::ip_proto_udp};
        hdr_words[5] = 16'h0000;
        hdr_words[6] = udp_gen_pkg::src_ip[31:16];
        hdr_words[7] = udp_gen_pkg::src_ip[15:0];
        hdr_words[8] = cfg_snap.dst_ip[31:16];
        hdr_words[9] = cfg_snap.dst_ip[15:0];
    end

    always_comb begin
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 20'(hdr_words[i]);
        end
    end

    // Two end-around carry folds are enough for a 20-bit sum
    assign fold1 = 17'(sum[15:0]) + 17'(sum[19:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            ip_csum <= '0;
        end else begin
            ip_csum <= ~fold2;
        end
    end

endmodule

// File: logic/pkt_tx_ctrl.sv
`timescale 1ns/1ps

module pkt_tx_ctrl (
    input  logic                    m00_axis_aclk,
    input  logic                    m00_axis_aresetn,
    input  logic [31:0]             delay,
    input  udp_gen_pkg::frame_cfg_t cfg_live,
    input  logic                    m00_axis_tready,
    output logic                    m00_axis_tvalid,
    output logic                    m00_axis_tlast,
    output logic [4:0]              beat_idx,
    output udp_gen_pkg::frame_cfg_t cfg_snap,
    output logic                    frame_done
);

    udp_gen_pkg::tx_state_e state;

    logic [31:0] timer;
    logic        trigger;
    logic        start;
    logic        last_beat;

    // Delay of zero stops the timer from firing
    assign trigger   = (delay != '0) && (timer == delay);
    assign start     = trigger && (state == udp_gen_pkg::st_idle);
    assign last_beat = (beat_idx == 5'(udp_gen_pkg::beats_per_frame - 1));

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            timer <= '0;
        end else if (trigger) begin
            timer <= '0;
        end else begin
            timer <= timer + 32'd1;   // Free running, also during a frame
        end
    end

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            state    <= udp_gen_pkg::st_idle;
            beat_idx <= 5'(udp_gen_pkg::beats_per_frame);   // Past the end, keep is zero
        end else begin
            case (state)
                udp_gen_pkg::st_idle: begin
                    if (start) begin
                        state    <= udp_gen_pkg::st_send;
                        beat_idx <= '0;
                    end
                end
                udp_gen_pkg::st_send: begin
                    if (m00_axis_tready) begin
                        beat_idx <= beat_idx + 5'd1;   // Leaves idx past the end after tlast
                        if (last_beat) begin
                            state <= udp_gen_pkg::st_done;
                        end
                    end
                end
                udp_gen_pkg::st_done: state <= udp_gen_pkg::st_idle;
                default:              state <= udp_gen_pkg::st_idle;
            endcase
        end
    end

    // Settings frozen for the whole frame
    always_ff @(posedge m00_axis_aclk) begin
        if (start) begin
            cfg_snap <= cfg_live;
        end
    end

    assign m00_axis_tvalid = (state == udp_gen_pkg::st_send);
    assign m00_axis_tlast  = m00_axis_tvalid && last_beat;
    assign frame_done      = (state == udp_gen_pkg::st_done);

endmodule

// File: logic/udp_frame_gen.sv
`timescale 1ns/1ps

module udp_frame_gen (
    input  logic                  m00_axis_aclk,
    input  logic                  m00_axis_aresetn,
    input  logic                  cfg_req,
    input  udp_gen_pkg::cfg_req_t cfg_cmd,
    output logic                  cfg_ack,
    output logic [31:0]           cfg_rdata,
    output logic                  m00_axis_tvalid,
    output logic [63:0]           m00_axis_tdata,
    output logic [7:0]            m00_axis_tkeep,
    output logic                  m00_axis_tlast,
    input  logic                  m00_axis_tready
);

    udp_gen_pkg::frame_cfg_t cfg_live;
    udp_gen_pkg::frame_cfg_t cfg_snap;
    udp_gen_pkg::beat_t      beat;

    logic [31:0] delay;
    logic        frame_done;
    logic [4:0]  beat_idx;
    logic [15:0] ip_csum;

    config_regs regs_i (
        .m00_axis_aclk   (m00_axis_aclk),
        .m00_axis_aresetn(m00_axis_aresetn),
        .cfg_req         (cfg_req),
        .cfg_cmd         (cfg_cmd),
        .cfg_ack         (cfg_ack),
        .cfg_rdata       (cfg_rdata),
        .frame_done      (frame_done),
        .cfg_live        (cfg_live),
        .delay           (delay)
    );

    pkt_tx_ctrl ctrl_i (
        .m00_axis_aclk   (m00_axis_aclk),
        .m00_axis_aresetn(m00_axis_aresetn),
        .delay           (delay),
        .cfg_live        (cfg_live),
        .m00_axis_tready (m00_axis_tready),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tlast  (m00_axis_tlast),
        .beat_idx        (beat_idx),
        .cfg_snap        (cfg_snap),
        .frame_done      (frame_done)
    );

    ip_checksum csum_i (
        .m00_axis_aclk   (m00_axis_aclk),
        .m00_axis_aresetn(m00_axis_aresetn),
        .cfg_snap        (cfg_snap),
        .ip_csum         (ip_csum)
    );

    frame_word_mux mux_i (
        .beat_idx(beat_idx),
        .cfg_snap(cfg_snap),
        .ip_csum (ip_csum),
        .beat    (beat)
    );

    assign m00_axis_tdata = beat.data;
    assign m00_axis_tkeep = beat.keep;

endmodule

// File: logic/udp_gen_pkg.sv
package udp_gen_pkg;

    // Stream port geometry
    localparam int data_w          = 64;
    localparam int keep_w          = 8;
    localparam int beats_per_frame = 22;
    localparam logic [keep_w-1:0] last_keep = 8'h03;   // 170 = 21*8 + 2 bytes

    // Frame layout
    localparam int hdr_bytes     = 42;    // Ethernet 14 + IPv4 20 + UDP 8
    localparam int payload_words = 64;    // 16-bit words

    // Register defaults
    localparam logic [31:0] default_delay   = 32'd200;
    localparam logic [47:0] default_dst_mac = 48'hFFFF_FFFF_FFFF;
    localparam logic [31:0] default_dst_ip  = {8'd192, 8'd168, 8'd4, 8'd1};

    // Fixed header fields
    localparam logic [47:0] src_mac      = 48'h001A_2B3C_4D5E;
    localparam logic [31:0] src_ip       = {8'd192, 8'd168, 8'd4, 8'd99};
    localparam logic [15:0] ether_type   = 16'h0800;   // IPv4
    localparam logic [7:0]  ip_ver_ihl   = 8'h45;
    localparam logic [15:0] ip_total_len = 16'd156;    // 20 + 8 + 128
    localparam logic [15:0] ip_id        = 16'h0001;
    localparam logic [15:0] ip_flags     = 16'h4000;   // Don't fragment
    localparam logic [7:0]  ip_ttl       = 8'd255;
    localparam logic [7:0]  ip_proto_udp = 8'd17;
    localparam logic [15:0] udp_port     = 16'd60133;  // Used for both source and dest
    localparam logic [15:0] udp_len      = 16'd136;    // 8 + 128

    // Host register map
    typedef enum logic [2:0] {
        reg_sent_count = 3'd0,   // Read only
        reg_delay      = 3'd1,
        reg_mac_hi     = 3'd2,   // MAC bytes 0..3, byte 0 in bits 31:24
        reg_mac_lo     = 3'd3,   // MAC bytes 4..5 in bits 15:0
        reg_dst_ip     = 3'd4
    } reg_addr_e;

    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_done
    } tx_state_e;

    // Per-frame destination settings
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [31:0] dst_ip;
    } frame_cfg_t;

    typedef struct packed {
        logic        we;
        reg_addr_e   addr;
        logic [31:0] wdata;
    } cfg_req_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [keep_w-1:0] keep;
    } beat_t;

endpackage

// File: project.f
logic/udp_gen_pkg.sv
logic/config_regs.sv
logic/ip_checksum.sv
logic/frame_word_mux.sv
logic/pkt_tx_ctrl.sv
logic/udp_frame_gen.sv
testbench/frame_checker.sv
testbench/tb_udp_frame_gen.sv

// File: testbench/frame_checker.sv
`timescale 1ns/1ps

module frame_checker (
    input  logic          m00_axis_aclk,
    input  logic          m00_axis_aresetn,
    input  logic          m00_axis_tvalid,
    input  logic [63:0]   m00_axis_tdata,
    input  logic [7:0]    m00_axis_tkeep,
    input  logic          m00_axis_tlast,
    input  logic          m00_axis_tready,
    input  logic [1359:0] exp_frame,   // Byte n of the frame in bits 8n+7:8n
    output int            frame_count,
    output int            error_count
);

    logic [1359:0] cur_frame;   // Model frame for the frame now on the wire
    logic [72:0]   held;
    logic          stalled;
    logic          in_frame;
    int            beat_cnt;

    task automatic flag_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_beat;
        logic [63:0] exp_data;
        logic [7:0]  exp_keep;
        int          b;
        for (int lane = 0; lane < 8; lane++) begin
            b = beat_cnt * 8 + lane;
            exp_keep[lane] = (b < 170);
            exp_data[lane*8 +: 8] = exp_keep[lane] ? cur_frame[b*8 +: 8] : 8'h00;
        end
        if (m00_axis_tdata !== exp_data)
            flag_error($sformatf("beat %0d data %h, expected %h", beat_cnt,
                                 m00_axis_tdata, exp_data));
        if (m00_axis_tkeep !== exp_keep)
            flag_error($sformatf("beat %0d keep %h, expected %h", beat_cnt,
                                 m00_axis_tkeep, exp_keep));
        if (m00_axis_tlast !== (beat_cnt == 21))
            flag_error($sformatf("beat %0d tlast %b", beat_cnt, m00_axis_tlast));
    endtask

    always @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            frame_count = 0;
            error_count = 0;
            beat_cnt    = 0;
            in_frame    = 1'b0;
            stalled     = 1'b0;
            held        = '0;
        end else begin
            // A stalled beat must hold until it is taken
            if (stalled && (!m00_axis_tvalid ||
                held !== {m00_axis_tdata, m00_axis_tkeep, m00_axis_tlast}))
                flag_error("stream changed while a beat was stalled");
            if (m00_axis_tvalid && !in_frame) begin
                cur_frame = exp_frame;   // Settings were frozen at the trigger
                in_frame  = 1'b1;
            end
            if (m00_axis_tvalid && m00_axis_tready) begin
                compare_beat();
                if (m00_axis_tlast || beat_cnt == 21) begin
                    frame_count++;
                    beat_cnt = 0;
                    in_frame = 1'b0;
                end else begin
                    beat_cnt++;
                end
            end
            stalled = m00_axis_tvalid && !m00_axis_tready;
            held    = {m00_axis_tdata, m00_axis_tkeep, m00_axis_tlast};
        end
    end

endmodule

// File: testbench/tb_udp_frame_gen.sv
`timescale 1ns/1ps

module tb_udp_frame_gen;

    localparam int n_frames   = 11;   // Frames waited on over all tests
    localparam int timeout_ns = n_frames * (200 + 22 * 4) * 4 + 1000 * 4 + 2000;

    logic                  m00_axis_aclk;
    logic                  m00_axis_aresetn;
    logic                  cfg_req;
    udp_gen_pkg::cfg_req_t cfg_cmd;
    logic                  cfg_ack;
    logic [31:0]           cfg_rdata;
    logic                  m00_axis_tvalid;
    logic [63:0]           m00_axis_tdata;
    logic [7:0]            m00_axis_tkeep;
    logic                  m00_axis_tlast;
    logic                  m00_axis_tready;
    logic [1359:0]         exp_frame;
    logic                  rand_ready;
    logic [47:0]           mac;
    logic [31:0]           ip;
    logic [31:0]           dly;
    logic [31:0]           dummy;
    integer                seed = 32'hc37f71ab;
    int                    frames;
    int                    frames_before;
    int                    chk_errors;
    int                    tb_errors;
    int                    errors_at_start;
    int                    tests_run;
    int                    valid_seen;

    udp_frame_gen dut_i (.*);

    frame_checker checker_i (
        .m00_axis_aclk   (m00_axis_aclk),
        .m00_axis_aresetn(m00_axis_aresetn),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tkeep  (m00_axis_tkeep),
        .m00_axis_tlast  (m00_axis_tlast),
        .m00_axis_tready (m00_axis_tready),
        .exp_frame       (exp_frame),
        .frame_count     (frames),
        .error_count     (chk_errors)
    );

    always #2 m00_axis_aclk = ~m00_axis_aclk;

    always @(negedge m00_axis_aclk) begin
        m00_axis_tready = rand_ready ? (($random(seed) % 2) != 0) : 1'b1;
    end

    // IPv4 header sum with the checksum field as zero, folded twice
    function automatic logic [15:0] ipv4_csum(input logic [31:0] dst);
        logic [31:0] sum;
        sum = 32'h4500 + 32'd156 + 32'h0001 + 32'h4000 + 32'hFF11 + 32'hC0A8 + 32'h0463;
        sum = sum + dst[31:16] + dst[15:0];
        sum = sum[15:0] + sum[31:16];
        sum = sum[15:0] + sum[31:16];
        return ~sum[15:0];
    endfunction

    function automatic logic [1359:0] build_frame(input logic [47:0] dmac, input logic [31:0] dip);
        logic [335:0]  hdr;
        logic [1359:0] f;
        logic [15:0]   val;
        hdr = {dmac, 48'h001A2B3C4D5E, 16'h0800, 16'h4500, 16'd156, 16'h0001, 16'h4000,
               8'hFF, 8'h11, ipv4_csum(dip), 32'hC0A80463, dip, 16'd60133, 16'd60133,
               16'd136, 16'h0000};
        for (int b = 0; b < 42; b++) f[b*8 +: 8] = hdr[(41 - b)*8 +: 8];
        for (int w = 0; w < 64; w++) begin
            val = (w % 2 == 0) ? 16'(w / 2) : 16'(255 - w / 2);
            f[(42 + 2*w)*8 +: 8] = val[7:0];   // Low byte first
            f[(43 + 2*w)*8 +: 8] = val[15:8];
        end
        return f;
    endfunction

    task automatic bus_access(input logic we, input udp_gen_pkg::reg_addr_e addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge m00_axis_aclk);
        cfg_cmd.we    = we;
        cfg_cmd.addr  = addr;
        cfg_cmd.wdata = wdata;
        cfg_req       = 1'b1;
        do @(negedge m00_axis_aclk); while (!cfg_ack);
        rdata   = cfg_rdata;
        cfg_req = 1'b0;
        do @(negedge m00_axis_aclk); while (cfg_ack);
    endtask

    task automatic check_reg(input udp_gen_pkg::reg_addr_e addr, input logic [31:0] expected);
        logic [31:0] got;
        bus_access(1'b0, addr, '0, got);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: register %0d read %h, expected %h",
                     $time, addr, got, expected);
            tb_errors++;
        end
    endtask

    task automatic wait_frame_start;
        do @(negedge m00_axis_aclk); while (m00_axis_tvalid);
        do @(negedge m00_axis_aclk); while (!m00_axis_tvalid);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames + n;
        while (frames < target) @(negedge m00_axis_aclk);
    endtask

    task automatic end_test(input string name);
        int now_errors;
        now_errors = tb_errors + chk_errors;
        if (now_errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, now_errors - errors_at_start);
        end
        errors_at_start = now_errors;
        tests_run++;
    endtask

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display("tests failed");
        $finish;
    end

    initial begin
        m00_axis_aclk    = 1'b0;
        m00_axis_aresetn = 1'b0;
        cfg_req          = 1'b0;
        cfg_cmd          = '0;
        m00_axis_tready  = 1'b1;
        rand_ready       = 1'b0;
        tb_errors        = 0;
        errors_at_start  = 0;
        tests_run        = 0;
        exp_frame = build_frame(48'hFFFF_FFFF_FFFF, {8'd192, 8'd168, 8'd4, 8'd1});
        repeat (10) @(negedge m00_axis_aclk);
        m00_axis_aresetn = 1'b1;

        wait_frames(2);
        end_test("default frames");

        // Accesses start just after a trigger, so the timer is still below any new delay
        wait_frame_start();
        bus_access(1'b1, udp_gen_pkg::reg_sent_count, $random(seed), dummy);
        check_reg(udp_gen_pkg::reg_sent_count, 32'(frames));
        dly = 100 + ($random(seed) & 63);
        mac[47:16] = $random(seed);
        mac[15:0]  = $random(seed);
        ip         = $random(seed);
        bus_access(1'b1, udp_gen_pkg::reg_delay, dly, dummy);
        bus_access(1'b1, udp_gen_pkg::reg_mac_hi, mac[47:16], dummy);
        bus_access(1'b1, udp_gen_pkg::reg_mac_lo, {16'h0000, mac[15:0]}, dummy);
        bus_access(1'b1, udp_gen_pkg::reg_dst_ip, ip, dummy);
        exp_frame = build_frame(mac, ip);   // Frame in flight keeps the old settings
        check_reg(udp_gen_pkg::reg_delay, dly);
        check_reg(udp_gen_pkg::reg_mac_hi, mac[47:16]);
        check_reg(udp_gen_pkg::reg_mac_lo, {16'h0000, mac[15:0]});
        check_reg(udp_gen_pkg::reg_dst_ip, ip);
        for (int a = 5; a < 8; a++) check_reg(udp_gen_pkg::reg_addr_e'(a), '0);
        end_test("register access");

        wait_frames(2);
        end_test("new MAC and IP");

        rand_ready = 1'b1;
        wait_frames(3);
        rand_ready = 1'b0;
        end_test("random tready");

        wait_frame_start();
        check_reg(udp_gen_pkg::reg_sent_count, 32'(frames));
        end_test("sent count");

        wait_frame_start();
        frames_before = frames;
        bus_access(1'b1, udp_gen_pkg::reg_delay, '0, dummy);
        do @(negedge m00_axis_aclk); while (m00_axis_tvalid);
        if (frames != frames_before + 1) begin
            $display("CHECK FAILED at %0t ns: frame in progress did not finish after delay 0",
                     $time);
            tb_errors++;
        end
        valid_seen = 0;
        repeat (1000) begin
            @(negedge m00_axis_aclk);
            if (m00_axis_tvalid) valid_seen++;
        end
        if (valid_seen != 0) begin
            $display("CHECK FAILED at %0t ns: tvalid high with delay 0", $time);
            tb_errors++;
        end
        end_test("delay zero");

        $display("Tests run: %0d, frames checked: %0d, errors: %0d",
                 tests_run, frames, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
